// ==== intra_pkg.sv ====
/* Shared definitions for the 4x4 luma intra mode decision engine
   block geometry, vector types, mode and picker state encodings */

package intra_pkg;

    // ----------------------------------------
    // Block geometry
    // ----------------------------------------
    localparam int blk_dim = 4;
    localparam int blk_pix = blk_dim * blk_dim;
    localparam int pix_w   = 8;
    localparam int lvl_w   = 9;

    // ----------------------------------------
    // Vector types
    // ----------------------------------------
    typedef logic [pix_w-1:0]                 pixel_t;
    // Pixel 0 in the lowest bits
    typedef logic [blk_dim*pix_w-1:0]         row_pix_t;
    typedef logic [blk_pix*pix_w-1:0]         block_pix_t;
    typedef logic signed [lvl_w-1:0]          level_t;
    typedef logic [blk_pix*lvl_w-1:0]         block_level_t;
    typedef logic [blk_pix-1:0]               nz_t;

    // Step is 1 << q_shift
    typedef logic [2:0]                       qshift_t;
    typedef logic [15:0]                      lambda_t;
    typedef logic [31:0]                      sse_t;
    typedef logic [15:0]                      rate_t;
    typedef logic [63:0]                      score_t;
    // Counted in blocks
    typedef logic [9:0]                       coord_t;

    // ----------------------------------------
    // Encodings
    // ----------------------------------------
    typedef enum logic [1:0] {
        mode_ve = 2'd0,
        mode_he = 2'd1,
        mode_tm = 2'd2,
        mode_dc = 2'd3
    } mode_t;

    typedef enum logic [2:0] {
        st_idle,
        st_pred,
        st_quant,
        st_meas,
        st_score,
        st_comp,
        st_done
    } pick_state_t;

    // Header bit cost per mode, vertical is cheapest
    localparam logic [9:0] mode_fixed_cost [4] = '{
        10'd663,
        10'd919,
        10'd872,
        10'd919
    };

endpackage

// ==== intra_pred_gen.sv ====
/* Intra predictor for one 4x4 luma block
   vertical, horizontal, true-motion and DC with neighbour availability */

`timescale 1ns/10ps

module intra_pred_gen (
    input  intra_pkg::mode_t      mode,
    input  intra_pkg::coord_t     pos_x,
    input  intra_pkg::coord_t     pos_y,
    input  intra_pkg::row_pix_t   top_row,
    input  intra_pkg::row_pix_t   left_col,
    input  intra_pkg::pixel_t     top_left,
    output intra_pkg::block_pix_t pred
);
    import intra_pkg::*;

    logic   have_top;
    logic   have_left;
    pixel_t dc_val;

    // Top row only above the first block row, left column likewise
    assign have_top  = (pos_y != '0);
    assign have_left = (pos_x != '0);

    // ----------------------------------------
    // DC value
    // ----------------------------------------
    always_comb begin
        logic [10:0] sum_top;
        logic [10:0] sum_left;
        logic [10:0] sum_all;
        sum_top  = '0;
        sum_left = '0;
        for (int k = 0; k < blk_dim; k++) begin
            sum_top  = sum_top + 11'(top_row[k*pix_w +: pix_w]);
            sum_left = sum_left + 11'(left_col[k*pix_w +: pix_w]);
        end
        sum_all = sum_top + sum_left;
        if (have_top && have_left) begin
            dc_val = pixel_t'((sum_all + 11'd4) >> 3);
        end else if (have_top) begin
            dc_val = pixel_t'((sum_top + 11'd2) >> 2);
        end else if (have_left) begin
            dc_val = pixel_t'((sum_left + 11'd2) >> 2);
        end else begin
            dc_val = pixel_t'(128);
        end
    end

    // ----------------------------------------
    // Per-pixel mux
    // ----------------------------------------
    always_comb begin
        pixel_t             t_pix;
        pixel_t             l_pix;
        logic signed [10:0] tm;
        pred = '0;
        for (int r = 0; r < blk_dim; r++) begin
            for (int c = 0; c < blk_dim; c++) begin
                t_pix = top_row[c*pix_w +: pix_w];
                l_pix = left_col[r*pix_w +: pix_w];
                tm    = $signed({3'b000, t_pix}) + $signed({3'b000, l_pix})
                        - $signed({3'b000, top_left});
                case (mode)
                    mode_ve: pred[(r*blk_dim+c)*pix_w +: pix_w] = t_pix;
                    mode_he: pred[(r*blk_dim+c)*pix_w +: pix_w] = l_pix;
                    mode_tm: begin
                        // Clamp to pixel range
                        if (tm < 0)
                            pred[(r*blk_dim+c)*pix_w +: pix_w] = '0;
                        else if (tm > 255)
                            pred[(r*blk_dim+c)*pix_w +: pix_w] = '1;
                        else
                            pred[(r*blk_dim+c)*pix_w +: pix_w] = tm[pix_w-1:0];
                    end
                    default: pred[(r*blk_dim+c)*pix_w +: pix_w] = dc_val;
                endcase
            end
        end
    end

endmodule

// ==== residual_quant.sv ====
/* Residual quantizer for one 4x4 block
   power-of-two step, dequant and clamped reconstruction, nonzero mask */

`timescale 1ns/10ps

module residual_quant (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  intra_pkg::block_pix_t   src,
    input  intra_pkg::block_pix_t   pred,
    input  intra_pkg::qshift_t      q_shift,
    output intra_pkg::block_pix_t   recon,
    output intra_pkg::block_level_t levels,
    output intra_pkg::nz_t          nz,
    output logic                    done
);
    import intra_pkg::*;

    logic [7:0]   half_step;
    block_pix_t   recon_d;
    block_level_t levels_d;
    nz_t          nz_d;

    // Rounding offset, none for unit step
    assign half_step = (q_shift == '0) ? 8'd0 : 8'(8'd1 << (q_shift - 3'd1));

    // ----------------------------------------
    // Quantize and reconstruct
    // ----------------------------------------
    always_comb begin
        logic signed [9:0]  resid;
        logic [8:0]         mag;
        logic [8:0]         qmag;
        level_t             lvl;
        logic signed [11:0] dq;
        logic signed [11:0] rec;
        for (int i = 0; i < blk_pix; i++) begin
            resid = $signed({2'b00, src[i*pix_w +: pix_w]})
                    - $signed({2'b00, pred[i*pix_w +: pix_w]});
            mag   = resid[9] ? 9'(-resid) : 9'(resid);
            qmag  = (mag + 9'(half_step)) >> q_shift;
            lvl   = resid[9] ? level_t'(-qmag) : level_t'(qmag);

            dq  = lvl;
            dq  = dq <<< q_shift;
            rec = $signed({4'b0000, pred[i*pix_w +: pix_w]}) + dq;

            if (rec < 0)
                recon_d[i*pix_w +: pix_w] = '0;
            else if (rec > 255)
                recon_d[i*pix_w +: pix_w] = '1;
            else
                recon_d[i*pix_w +: pix_w] = rec[pix_w-1:0];

            levels_d[i*lvl_w +: lvl_w] = lvl;
            nz_d[i]                    = (lvl != '0);
        end
    end

    // ----------------------------------------
    // Output stage
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done <= 1'b0;
        end else begin
            done <= start;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            recon  <= recon_d;
            levels <= levels_d;
            nz     <= nz_d;
        end
    end

    // One result per start pulse
    a_done_single: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !done);

endmodule

// ==== block_metrics.sv ====
/* Candidate metrics for one 4x4 block
   sum of squared error against the source and sum of absolute levels */

`timescale 1ns/10ps

module block_metrics (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  intra_pkg::block_pix_t   src,
    input  intra_pkg::block_pix_t   recon,
    input  intra_pkg::block_level_t levels,
    output intra_pkg::sse_t         sse,
    output intra_pkg::rate_t        rate,
    output logic                    done
);
    import intra_pkg::*;

    sse_t  sse_d;
    rate_t rate_d;

    always_comb begin
        logic signed [8:0] diff;
        logic [16:0]       sq;
        level_t            lvl;
        logic [8:0]        lvl_abs;
        sse_d  = '0;
        rate_d = '0;
        for (int i = 0; i < blk_pix; i++) begin
            diff = $signed({1'b0, src[i*pix_w +: pix_w]})
                   - $signed({1'b0, recon[i*pix_w +: pix_w]});
            sq   = 17'(diff * diff);
            sse_d = sse_d + sse_t'(sq);

            lvl     = levels[i*lvl_w +: lvl_w];
            lvl_abs = lvl[lvl_w-1] ? 9'(-lvl) : 9'(lvl);
            rate_d  = rate_d + rate_t'(lvl_abs);
        end
    end

    // ----------------------------------------
    // Registered result
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done <= 1'b0;
        end else begin
            done <= start;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            sse  <= sse_d;
            rate <= rate_d;
        end
    end

endmodule

// ==== intra_mode_picker.sv ====
/* Intra mode picker for one 4x4 luma block
   steps through ve, he, tm and dc and keeps the lowest score */

`timescale 1ns/10ps

module intra_mode_picker (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  intra_pkg::coord_t       pos_x,
    input  intra_pkg::coord_t       pos_y,
    input  intra_pkg::block_pix_t   src,
    input  intra_pkg::row_pix_t     top_row,
    input  intra_pkg::row_pix_t     left_col,
    input  intra_pkg::pixel_t       top_left,
    input  intra_pkg::qshift_t      q_shift,
    input  intra_pkg::lambda_t      lambda,
    output intra_pkg::mode_t        best_mode,
    output intra_pkg::score_t       best_score,
    output intra_pkg::block_pix_t   best_recon,
    output intra_pkg::block_level_t best_levels,
    output intra_pkg::nz_t          best_nz,
    output logic                    done
);
    import intra_pkg::*;

    pick_state_t  state;
    pick_state_t  state_nxt;
    mode_t        cur_mode;
    block_pix_t   pred_d;
    block_pix_t   pred_q;
    logic         quant_start;
    logic         quant_done;
    logic         meas_done;
    logic         meas_busy;
    block_pix_t   recon;
    block_level_t levels;
    nz_t          nz;
    sse_t         sse;
    rate_t        rate;
    score_t       score_calc;
    score_t       cand_score;
    logic         keep;

    intra_pred_gen u_pred (
        .mode     (cur_mode),
        .pos_x    (pos_x),
        .pos_y    (pos_y),
        .top_row  (top_row),
        .left_col (left_col),
        .top_left (top_left),
        .pred     (pred_d)
    );

    residual_quant u_quant (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (quant_start),
        .src     (src),
        .pred    (pred_q),
        .q_shift (q_shift),
        .recon   (recon),
        .levels  (levels),
        .nz      (nz),
        .done    (quant_done)
    );

    block_metrics u_meas (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (quant_done),
        .src    (src),
        .recon  (recon),
        .levels (levels),
        .sse    (sse),
        .rate   (rate),
        .done   (meas_done)
    );

    // Rate-weighted cost plus 256 x SSE
    assign score_calc = (((score_t'(rate) << 10) + score_t'(mode_fixed_cost[cur_mode]))
                        * score_t'(lambda)) + (score_t'(sse) << 8);

    // First mode always wins, later ones only when strictly better
    assign keep = (cur_mode == mode_ve) || (cand_score < best_score);

    // ----------------------------------------
    // FSM
    // ----------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            st_idle:  if (start) state_nxt = st_pred;
            st_pred:  state_nxt = st_quant;
            st_quant: state_nxt = st_meas;
            st_meas:  state_nxt = st_score;
            st_score: if (meas_done) state_nxt = st_comp;
            st_comp:  state_nxt = (cur_mode == mode_dc) ? st_done : st_pred;
            st_done:  state_nxt = st_idle;
            default:  state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= st_idle;
            cur_mode    <= mode_ve;
            quant_start <= 1'b0;
            meas_busy   <= 1'b0;
            done        <= 1'b0;
            best_mode   <= mode_ve;
            best_score  <= '0;
        end else begin
            state       <= state_nxt;
            quant_start <= (state == st_pred);
            done        <= (state == st_comp) && (cur_mode == mode_dc);

            if (quant_done)
                meas_busy <= 1'b1;
            else if (meas_done)
                meas_busy <= 1'b0;

            if (state == st_idle && start)
                cur_mode <= mode_ve;
            else if (state == st_comp && cur_mode != mode_dc)
                cur_mode <= mode_t'(cur_mode + 2'd1);

            if (state == st_comp && keep) begin
                best_mode  <= cur_mode;
                best_score <= cand_score;
            end
        end
    end

    // ----------------------------------------
    // Candidate payload
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (state == st_pred)
            pred_q <= pred_d;
        if (state == st_score && meas_done)
            cand_score <= score_calc;
        if (state == st_comp && keep) begin
            best_recon  <= recon;
            best_levels <= levels;
            best_nz     <= nz;
        end
    end

    a_done_state: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> state == st_done);

    // Quantizer must not overwrite data still being measured
    a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
        quant_start |-> !(quant_done || meas_busy));

endmodule

// ==== intra_luma_top.sv ====
/* Luma intra decision engine with valid/ready handshakes
   captures one block, runs the mode picker, holds the result until taken */

`timescale 1ns/10ps

module intra_luma_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_valid,
    output logic                    in_ready,
    input  intra_pkg::coord_t       pos_x,
    input  intra_pkg::coord_t       pos_y,
    input  intra_pkg::block_pix_t   src,
    input  intra_pkg::row_pix_t     top_row,
    input  intra_pkg::row_pix_t     left_col,
    input  intra_pkg::pixel_t       top_left,
    input  intra_pkg::qshift_t      q_shift,
    input  intra_pkg::lambda_t      lambda,
    output logic                    out_valid,
    input  logic                    out_ready,
    output intra_pkg::mode_t        best_mode,
    output intra_pkg::score_t       best_score,
    output intra_pkg::block_pix_t   best_recon,
    output intra_pkg::block_level_t best_levels,
    output intra_pkg::nz_t          best_nz
);
    import intra_pkg::*;

    logic       busy;
    logic       holding;
    logic       accept;
    logic       pick_start;
    logic       pick_done;
    coord_t     pos_x_q;
    coord_t     pos_y_q;
    block_pix_t src_q;
    row_pix_t   top_row_q;
    row_pix_t   left_col_q;
    pixel_t     top_left_q;
    qshift_t    q_shift_q;
    lambda_t    lambda_q;

    assign in_ready  = !busy && !holding;
    assign out_valid = holding;
    assign accept    = in_valid && in_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            holding    <= 1'b0;
            pick_start <= 1'b0;
        end else begin
            pick_start <= accept;
            if (accept)
                busy <= 1'b1;
            else if (pick_done)
                busy <= 1'b0;
            if (pick_done)
                holding <= 1'b1;
            else if (holding && out_ready)
                holding <= 1'b0;
        end
    end

    // Input block capture
    always_ff @(posedge clk) begin
        if (accept) begin
            pos_x_q    <= pos_x;
            pos_y_q    <= pos_y;
            src_q      <= src;
            top_row_q  <= top_row;
            left_col_q <= left_col;
            top_left_q <= top_left;
            q_shift_q  <= q_shift;
            lambda_q   <= lambda;
        end
    end

    intra_mode_picker u_picker (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (pick_start),
        .pos_x       (pos_x_q),
        .pos_y       (pos_y_q),
        .src         (src_q),
        .top_row     (top_row_q),
        .left_col    (left_col_q),
        .top_left    (top_left_q),
        .q_shift     (q_shift_q),
        .lambda      (lambda_q),
        .best_mode   (best_mode),
        .best_score  (best_score),
        .best_recon  (best_recon),
        .best_levels (best_levels),
        .best_nz     (best_nz),
        .done        (pick_done)
    );

    a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(best_score));

endmodule

// ==== tb_intra_luma.sv ====
/* Testbench for the luma intra decision engine
   reference model, random and directed blocks, output back-pressure */

`timescale 1ns/10ps

module tb_intra_luma;
    import intra_pkg::*;

    localparam int fixed_cost [4] = '{663, 919, 872, 919};
    localparam int hs_limit    = 200;
    localparam int drain_limit = 5000;

    logic         clk;
    logic         rst_n;
    logic         in_valid;
    logic         in_ready;
    logic         out_valid;
    logic         out_ready;
    coord_t       pos_x;
    coord_t       pos_y;
    block_pix_t   src;
    row_pix_t     top_row;
    row_pix_t     left_col;
    pixel_t       top_left;
    qshift_t      q_shift;
    lambda_t      lambda;
    mode_t        best_mode;
    score_t       best_score;
    block_pix_t   best_recon;
    block_level_t best_levels;
    nz_t          best_nz;

    int           err_cnt;
    int           tmo_cnt;
    int           sent_cnt;
    int           recv_cnt;
    logic         bp_on;

    // Expected results in issue order
    mode_t        exp_mode_q[$];
    score_t       exp_score_q[$];
    block_pix_t   exp_recon_q[$];
    block_level_t exp_levels_q[$];
    nz_t          exp_nz_q[$];

    intra_luma_top DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .pos_x       (pos_x),
        .pos_y       (pos_y),
        .src         (src),
        .top_row     (top_row),
        .left_col    (left_col),
        .top_left    (top_left),
        .q_shift     (q_shift),
        .lambda      (lambda),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .best_mode   (best_mode),
        .best_score  (best_score),
        .best_recon  (best_recon),
        .best_levels (best_levels),
        .best_nz     (best_nz)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    function automatic int clip_pix(input int v);
        return (v < 0) ? 0 : ((v > 255) ? 255 : v);
    endfunction

    function automatic int predict_pix(input int mode, input int r, input int c,
                                       input coord_t px, input coord_t py,
                                       input row_pix_t t, input row_pix_t l,
                                       input pixel_t tl);
        int tp;
        int lp;
        int tlv;
        int st;
        int sl;
        tp  = t[c*pix_w +: pix_w];
        lp  = l[r*pix_w +: pix_w];
        tlv = tl;
        st  = 0;
        sl  = 0;
        for (int k = 0; k < blk_dim; k++) begin
            st += t[k*pix_w +: pix_w];
            sl += l[k*pix_w +: pix_w];
        end
        case (mode)
            0: return tp;
            1: return lp;
            2: return clip_pix(tp + lp - tlv);
            default: begin
                // Only neighbours that exist feed DC
                if (py != 0 && px != 0)
                    return (st + sl + 4) >> 3;
                else if (py != 0)
                    return (st + 2) >> 2;
                else if (px != 0)
                    return (sl + 2) >> 2;
                else
                    return 128;
            end
        endcase
    endfunction

    function automatic void ref_pick(input coord_t px, input coord_t py,
                                     input block_pix_t s, input row_pix_t t,
                                     input row_pix_t l, input pixel_t tl,
                                     input qshift_t qs, input lambda_t lam,
                                     output mode_t m_best, output score_t sc_best,
                                     output block_pix_t rec_best,
                                     output block_level_t lv_best,
                                     output nz_t nz_best);
        block_pix_t   rec;
        block_level_t lv;
        nz_t          nz;
        score_t       sc;
        int           p;
        int           sv;
        int           d;
        int           mag;
        int           q;
        int           lvl;
        int           r_pix;
        int           rate;
        int           sse;
        int           half;
        half     = (qs == 0) ? 0 : (1 << (qs - 1));
        m_best   = mode_ve;
        sc_best  = '0;
        rec_best = '0;
        lv_best  = '0;
        nz_best  = '0;
        for (int m = 0; m < 4; m++) begin
            rate = 0;
            sse  = 0;
            for (int i = 0; i < blk_pix; i++) begin
                p     = predict_pix(m, i / blk_dim, i % blk_dim, px, py, t, l, tl);
                sv    = s[i*pix_w +: pix_w];
                d     = sv - p;
                mag   = (d < 0) ? -d : d;
                q     = (mag + half) >> qs;
                lvl   = (d < 0) ? -q : q;
                r_pix = clip_pix(p + lvl * (1 << qs));
                rec[i*pix_w +: pix_w] = pixel_t'(r_pix);
                lv[i*lvl_w +: lvl_w]  = level_t'(lvl);
                nz[i] = (lvl != 0);
                sse  += (sv - r_pix) * (sv - r_pix);
                rate += q;
            end
            sc = ((score_t'(rate) << 10) + score_t'(fixed_cost[m])) * score_t'(lam)
                 + (score_t'(sse) << 8);
            // Strictly lower wins, so ties stay with the lower mode
            if (m == 0 || sc < sc_best) begin
                m_best   = mode_t'(m);
                sc_best  = sc;
                rec_best = rec;
                lv_best  = lv;
                nz_best  = nz;
            end
        end
    endfunction

    // ----------------------------------------
    // Compare tasks
    // ----------------------------------------
    task automatic mode_cmp(input string name, input mode_t got, input mode_t exp);
        if (got !== exp) begin
            $display("ERROR %s got %h expected %h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic score_cmp(input string name, input score_t got, input score_t exp);
        if (got !== exp) begin
            $display("ERROR %s got %h expected %h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic pix_cmp(input string name, input block_pix_t got, input block_pix_t exp);
        if (got !== exp) begin
            $display("ERROR %s got %h expected %h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic level_cmp(input string name, input block_level_t got,
                             input block_level_t exp);
        if (got !== exp) begin
            $display("ERROR %s got %h expected %h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic nz_cmp(input string name, input nz_t got, input nz_t exp);
        if (got !== exp) begin
            $display("ERROR %s got %h expected %h", name, got, exp);
            err_cnt++;
        end
    endtask

    // ----------------------------------------
    // Stimulus helpers
    // ----------------------------------------
    function automatic block_pix_t rand_block();
        block_pix_t b;
        for (int i = 0; i < blk_pix; i++)
            b[i*pix_w +: pix_w] = pixel_t'($urandom);
        return b;
    endfunction

    function automatic row_pix_t rand_row(input int base, input int span);
        row_pix_t r;
        for (int k = 0; k < blk_dim; k++)
            r[k*pix_w +: pix_w] = pixel_t'(base + $urandom % span);
        return r;
    endfunction

    // About a quarter of positions on the picture edge
    function automatic coord_t rand_pos();
        return ($urandom % 4 == 0) ? coord_t'(0) : coord_t'($urandom);
    endfunction

    // Called and returns on a falling edge
    task automatic send_block(input coord_t px, input coord_t py, input block_pix_t s,
                              input row_pix_t t, input row_pix_t l, input pixel_t tl,
                              input qshift_t qs, input lambda_t lam);
        mode_t        e_mode;
        score_t       e_score;
        block_pix_t   e_rec;
        block_level_t e_lv;
        nz_t          e_nz;
        int           waited;
        ref_pick(px, py, s, t, l, tl, qs, lam, e_mode, e_score, e_rec, e_lv, e_nz);
        // Unit step reproduces the source exactly
        if (qs == 0)
            e_rec = s;
        pos_x    = px;
        pos_y    = py;
        src      = s;
        top_row  = t;
        left_col = l;
        top_left = tl;
        q_shift  = qs;
        lambda   = lam;
        in_valid = 1'b1;
        waited   = 0;
        while (!in_ready && waited < hs_limit) begin
            @(negedge clk);
            waited++;
        end
        if (!in_ready) begin
            $display("Timeout: in_ready never rose for block %0d", sent_cnt);
            tmo_cnt++;
        end else begin
            exp_mode_q.push_back(e_mode);
            exp_score_q.push_back(e_score);
            exp_recon_q.push_back(e_rec);
            exp_levels_q.push_back(e_lv);
            exp_nz_q.push_back(e_nz);
            sent_cnt++;
            @(negedge clk);
        end
        in_valid = 1'b0;
    endtask

    // ----------------------------------------
    // Output monitor
    // ----------------------------------------
    initial begin
        mode_t        h_mode;
        score_t       h_score;
        block_pix_t   h_recon;
        block_level_t h_levels;
        nz_t          h_nz;
        logic         hold_chk;
        int           stretch;
        hold_chk = 1'b0;
        stretch  = 0;
        forever begin
            @(negedge clk);
            if (!bp_on) begin
                out_ready = 1'b1;
            end else if (stretch == 0) begin
                out_ready = ($urandom % 2) == 1;
                stretch   = 1 + $urandom % 8;
            end
            if (stretch > 0)
                stretch--;

            if (hold_chk) begin
                if (!out_valid) begin
                    $display("out_valid dropped before the result was accepted");
                    err_cnt++;
                end
                mode_cmp("best_mode (held)", best_mode, h_mode);
                score_cmp("best_score (held)", best_score, h_score);
                pix_cmp("best_recon (held)", best_recon, h_recon);
                level_cmp("best_levels (held)", best_levels, h_levels);
                nz_cmp("best_nz (held)", best_nz, h_nz);
            end
            if (out_valid && in_ready) begin
                $display("in_ready is high while a result is still waiting");
                err_cnt++;
            end

            if (out_valid && out_ready) begin
                recv_cnt++;
                hold_chk = 1'b0;
                if (exp_mode_q.size() == 0) begin
                    $display("A result came out with no block outstanding");
                    err_cnt++;
                end else begin
                    mode_cmp("best_mode", best_mode, exp_mode_q.pop_front());
                    score_cmp("best_score", best_score, exp_score_q.pop_front());
                    pix_cmp("best_recon", best_recon, exp_recon_q.pop_front());
                    level_cmp("best_levels", best_levels, exp_levels_q.pop_front());
                    nz_cmp("best_nz", best_nz, exp_nz_q.pop_front());
                end
            end else if (out_valid) begin
                hold_chk = 1'b1;
                h_mode   = best_mode;
                h_score  = best_score;
                h_recon  = best_recon;
                h_levels = best_levels;
                h_nz     = best_nz;
            end else begin
                hold_chk = 1'b0;
            end
        end
    end

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        int waited;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        out_ready = 1'b0;
        pos_x     = '0;
        pos_y     = '0;
        src       = '0;
        top_row   = '0;
        left_col  = '0;
        top_left  = '0;
        q_shift   = '0;
        lambda    = '0;
        bp_on     = 1'b0;
        err_cnt   = 0;
        tmo_cnt   = 0;
        sent_cnt  = 0;
        recv_cnt  = 0;
        void'($urandom(32'hbf79));

        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        if (in_ready !== 1'b1 || out_valid !== 1'b0) begin
            $display("After reset in_ready should be high and out_valid low");
            err_cnt++;
        end

        // DC availability on a flat mid-grey source
        // Top mean 120 and left mean 136 with wide spread, so DC wins everywhere
        send_block(10'd0, 10'd0, {16{8'h80}}, 32'hd020e010, 32'h20e820f8, 8'h10, 3'd3, 16'd200);
        send_block(10'd0, 10'd5, {16{8'h80}}, 32'hd020e010, 32'h20e820f8, 8'h10, 3'd3, 16'd200);
        send_block(10'd6, 10'd0, {16{8'h80}}, 32'hd020e010, 32'h20e820f8, 8'h10, 3'd3, 16'd200);
        send_block(10'd3, 10'd9, {16{8'h80}}, 32'hd020e010, 32'h20e820f8, 8'h10, 3'd3, 16'd200);

        // Lossless step with a flat block first
        send_block(10'd1, 10'd1, {16{8'h55}}, {4{8'h55}}, {4{8'h55}}, 8'h55, 3'd0, 16'd77);
        for (int n = 0; n < 8; n++)
            send_block(rand_pos(), rand_pos(), rand_block(), rand_row(0, 256),
                       rand_row(0, 256), pixel_t'($urandom), 3'd0, lambda_t'($urandom));

        // True-motion overflow and underflow
        for (int n = 0; n < 10; n++) begin
            send_block(rand_pos(), rand_pos(), rand_block(), rand_row(248, 8),
                       rand_row(248, 8), pixel_t'($urandom % 8), qshift_t'($urandom),
                       lambda_t'($urandom % 64));
            send_block(rand_pos(), rand_pos(), rand_block(), rand_row(0, 8),
                       rand_row(0, 8), pixel_t'(248 + $urandom % 8), qshift_t'($urandom),
                       lambda_t'($urandom % 64));
        end

        // Random traffic with back-pressure on the second half
        for (int n = 0; n < 200; n++) begin
            bp_on = (n >= 100);
            send_block(rand_pos(), rand_pos(), rand_block(), rand_row(0, 256),
                       rand_row(0, 256), pixel_t'($urandom), qshift_t'($urandom),
                       lambda_t'($urandom));
        end

        waited = 0;
        while (exp_mode_q.size() != 0 && waited < drain_limit) begin
            @(negedge clk);
            waited++;
        end
        if (exp_mode_q.size() != 0) begin
            $display("Timeout: %0d results never came out", exp_mode_q.size());
            tmo_cnt++;
        end
        // Window to catch a duplicated result
        repeat (40) @(negedge clk);
        if (recv_cnt != sent_cnt) begin
            $display("Sent %0d blocks but received %0d results", sent_cnt, recv_cnt);
            err_cnt++;
        end

        $display("Errors: %0d  Timeouts: %0d", err_cnt, tmo_cnt);
        if (err_cnt == 0 && tmo_cnt == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// ==== intra_luma_top.f ====
intra_pkg.sv
intra_pred_gen.sv
residual_quant.sv
block_metrics.sv
intra_mode_picker.sv
intra_luma_top.sv
tb_intra_luma.sv
